// File: hdl/xdom_pkg.sv
// xdom register core package with bus widths, register map, shared structs and idle values
package xdom_pkg;

  localparam int ADR_W    = 12;
  localparam int DATA_W   = 16;
  localparam int CH_SEL_W = 5;
  localparam int PULSER_N = 6;

  // one host access with single-cycle strobes
  typedef struct packed {
    logic              wr;
    logic              rd;
    logic [ADR_W-1:0]  adr;
    logic [DATA_W-1:0] data;
  } host_bus_t;

  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
  } rd_resp_t;

  typedef struct packed {
    logic        ext_en;
    logic        thr_en;
    logic        disc_en;
    logic        disc_pol;
    logic        lt;
    logic        gt;
    logic        et;
    logic [11:0] thr;
  } trig_conf_t;

  // dac uses sel[2:0], adc uses data[23:0]
  typedef struct packed {
    logic        req;
    logic [5:0]  sel;
    logic [31:0] data;
  } spi_cmd_t;

  typedef struct packed {
    logic [1:0] delay_ce;
    logic [1:0] delay_inc;
    logic [1:0] adc_bitslip;
    logic       disc_bitslip;
  } io_strobe_t;

  localparam trig_conf_t TRIG_CONF_RST  = '0;
  localparam io_strobe_t IO_STROBE_IDLE = '0;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  localparam logic [ADR_W-1:0] ADR_VNUM             = 12'hfff;
  localparam logic [ADR_W-1:0] ADR_TRIG_CONF        = 12'hbfe;
  localparam logic [ADR_W-1:0] ADR_TRIG_THR         = 12'hbfd;
  localparam logic [ADR_W-1:0] ADR_SW_MASK_HI       = 12'hbfc;
  localparam logic [ADR_W-1:0] ADR_SW_MASK_LO       = 12'hbfb;
  localparam logic [ADR_W-1:0] ADR_ARM_MASK_HI      = 12'hbfa;
  localparam logic [ADR_W-1:0] ADR_ARM_MASK_LO      = 12'hbf9;
  localparam logic [ADR_W-1:0] ADR_TRIG_CMD         = 12'hbf8;
  localparam logic [ADR_W-1:0] ADR_ARMED_HI         = 12'hbf6;
  localparam logic [ADR_W-1:0] ADR_ARMED_LO         = 12'hbf5;
  localparam logic [ADR_W-1:0] ADR_BUF_SEL          = 12'hbef;
  localparam logic [ADR_W-1:0] ADR_BUF_WDS          = 12'hbed;
  localparam logic [ADR_W-1:0] ADR_IO_SEL           = 12'hbe6;
  localparam logic [ADR_W-1:0] ADR_IO_STROBE        = 12'hbe5;
  localparam logic [ADR_W-1:0] ADR_ADC_SEL          = 12'hbdc;
  localparam logic [ADR_W-1:0] ADR_ADC_TASK         = 12'hbdb;
  localparam logic [ADR_W-1:0] ADR_ADC_DATA_HI      = 12'hbda;
  localparam logic [ADR_W-1:0] ADR_ADC_DATA_LO      = 12'hbd9;
  localparam logic [ADR_W-1:0] ADR_ADC_RD           = 12'hbd8;
  localparam logic [ADR_W-1:0] ADR_DAC_SEL          = 12'hbd7;
  localparam logic [ADR_W-1:0] ADR_DAC_TASK         = 12'hbd5;
  localparam logic [ADR_W-1:0] ADR_DAC_DATA_HI      = 12'hbd4;
  localparam logic [ADR_W-1:0] ADR_DAC_DATA_LO      = 12'hbd3;
  localparam logic [ADR_W-1:0] ADR_PULSER_WIDTH     = 12'hbd2;
  localparam logic [ADR_W-1:0] ADR_PULSER_SINGLE    = 12'hbce;
  localparam logic [ADR_W-1:0] ADR_SCALER_SEL       = 12'hbb8;
  localparam logic [ADR_W-1:0] ADR_SCALER_HI        = 12'hbb7;
  localparam logic [ADR_W-1:0] ADR_SCALER_LO        = 12'hbb6;
  localparam logic [ADR_W-1:0] ADR_PULSER_PERIOD_HI = 12'hbb3;
  localparam logic [ADR_W-1:0] ADR_PULSER_PERIOD_LO = 12'hbb2;
  localparam logic [ADR_W-1:0] ADR_PULSER_EN        = 12'hbb1;

endpackage

// File: hdl/task_handshake.sv
// request/acknowledge handshake for one serial-bus task
module task_handshake (
  input  logic clk,
  input  logic rst,
  input  logic i_start,
  input  logic i_ack,
  output logic o_req,
  output logic o_val
);

  typedef enum logic {
    ST_IDLE,
    ST_REQ
  } state_t;

  state_t state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          // device may still hold ack from the last transfer
          if (i_start && !i_ack) begin
            state <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (i_ack) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign o_req = (state == ST_REQ);

  // busy while requesting or while the device still acknowledges
  assign o_val = o_req | i_ack;

endmodule

// File: hdl/channel_sel_mux.sv
// registered per-channel word selector that gives zero past the last channel
module channel_sel_mux import xdom_pkg::*; #(
  parameter type payload_t  = logic [15:0],
  parameter int  N_CHANNELS = 24
) (
  input  logic                     clk,
  input  logic [CH_SEL_W-1:0]      i_sel,
  input  payload_t [N_CHANNELS-1:0] i_data,
  output payload_t                 o_data
);

  always_ff @(posedge clk) begin
    if (i_sel < N_CHANNELS) begin
      o_data <= i_data[i_sel];
    end else begin
      o_data <= '0;
    end
  end

endmodule

// File: hdl/io_strobe_demux.sv
// steers the adc delay and bitslip strobe pattern onto the selected channel
module io_strobe_demux import xdom_pkg::*; #(
  parameter int N_CHANNELS = 24
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [CH_SEL_W-1:0]         i_sel,
  input  io_strobe_t                  i_pattern,
  output io_strobe_t [N_CHANNELS-1:0] o_strobe
);

  always_ff @(posedge clk) begin
    for (int ch = 0; ch < N_CHANNELS; ch++) begin
      if (rst) begin
        o_strobe[ch] <= IO_STROBE_IDLE;
      end else if (i_sel == CH_SEL_W'(ch)) begin
        o_strobe[ch] <= i_pattern;
      end else begin
        // unselected channels see no strobe
        o_strobe[ch] <= IO_STROBE_IDLE;
      end
    end
  end

endmodule

// File: hdl/periodic_trigger.sv
// periodic pulse generator with one high cycle every i_period cycles
module periodic_trigger (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] i_period,
  output logic        o_trig
);

  logic [31:0] count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count  <= '0;
      o_trig <= 1'b0;
    end else if (i_period == '0) begin
      // idle until a period is programmed
      count  <= '0;
      o_trig <= 1'b0;
    end else if (count == '0) begin
      count  <= i_period - 32'd1;
      o_trig <= 1'b1;
    end else begin
      count  <= count - 32'd1;
      o_trig <= 1'b0;
    end
  end

endmodule

// File: hdl/reg_file.sv
// host register file: write decode, self-clearing strobes and registered read response
module reg_file import xdom_pkg::*; #(
  parameter int N_CHANNELS = 24
) (
  input  logic                  clk,
  input  logic                  rst,
  input  host_bus_t             i_bus,
  output rd_resp_t              o_rd,
  input  logic [15:0]           i_vnum,
  input  logic [N_CHANNELS-1:0] i_wvb_armed,
  input  logic [15:0]           i_wds_sel_data,
  input  logic [31:0]           i_scaler_sel_data,
  input  logic [7:0]            i_adc_rd_data,
  input  logic                  i_adc_task_val,
  input  logic                  i_dac_task_val,
  output logic                  o_adc_start,
  output logic                  o_dac_start,
  output spi_cmd_t              o_adc_cmd,
  output spi_cmd_t              o_dac_cmd,
  output logic [CH_SEL_W-1:0]   o_buf_sel,
  output logic [CH_SEL_W-1:0]   o_scaler_sel,
  output logic [CH_SEL_W-1:0]   o_io_sel,
  output io_strobe_t            o_io_pattern,
  output trig_conf_t            o_trig_conf,
  output logic [N_CHANNELS-1:0] o_trig_run,
  output logic [N_CHANNELS-1:0] o_wvb_arm,
  output logic [PULSER_N-1:0]   o_pulser_single,
  output logic [PULSER_N-1:0]   o_pulser_en,
  output logic [31:0]           o_pulser_period,
  output logic [15:0]           o_pulser_width
);

  // channel masks split into a low word and a partial high word
  localparam int HI_W = N_CHANNELS - 16;

  logic [N_CHANNELS-1:0] sw_mask;
  logic [N_CHANNELS-1:0] arm_mask;
  logic [5:0]            adc_sel;
  logic [23:0]           adc_data;
  logic [2:0]            dac_sel;
  logic [31:0]           dac_data;
  logic [DATA_W-1:0]     wd;
  logic [DATA_W-1:0]     rd_word;
  logic                  rd_valid;
  logic [DATA_W-1:0]     rd_data;

  assign wd = i_bus.data;

  //////////////////////////////////////////////////////////////////////////
  // write side
  always_ff @(posedge clk) begin
    if (rst) begin
      o_trig_conf     <= TRIG_CONF_RST;
      sw_mask         <= '0;
      arm_mask        <= '0;
      adc_sel         <= '0;
      adc_data        <= '0;
      dac_sel         <= '0;
      dac_data        <= '0;
      o_buf_sel       <= '0;
      o_scaler_sel    <= '0;
      o_io_sel        <= '0;
      o_pulser_en     <= '0;
      o_pulser_period <= '0;
      o_pulser_width  <= '0;
      o_trig_run      <= '0;
      o_wvb_arm       <= '0;
      o_io_pattern    <= IO_STROBE_IDLE;
      o_pulser_single <= '0;
      o_adc_start     <= 1'b0;
      o_dac_start     <= 1'b0;
    end else begin
      // one-cycle strobes fall back unless rewritten
      o_trig_run      <= '0;
      o_wvb_arm       <= '0;
      o_io_pattern    <= IO_STROBE_IDLE;
      o_pulser_single <= '0;
      o_adc_start     <= 1'b0;
      o_dac_start     <= 1'b0;
      if (i_bus.wr) begin
        case (i_bus.adr)
          ADR_TRIG_CONF: begin
            o_trig_conf.et       <= wd[0];
            o_trig_conf.gt       <= wd[1];
            o_trig_conf.lt       <= wd[2];
            o_trig_conf.disc_pol <= wd[3];
            o_trig_conf.disc_en  <= wd[4];
            o_trig_conf.thr_en   <= wd[5];
            o_trig_conf.ext_en   <= wd[6];
          end
          ADR_TRIG_THR:    o_trig_conf.thr <= wd[11:0];
          ADR_SW_MASK_HI:  sw_mask[N_CHANNELS-1:16] <= wd[HI_W-1:0];
          ADR_SW_MASK_LO:  sw_mask[15:0] <= wd;
          ADR_ARM_MASK_HI: arm_mask[N_CHANNELS-1:16] <= wd[HI_W-1:0];
          ADR_ARM_MASK_LO: arm_mask[15:0] <= wd;
          ADR_TRIG_CMD: begin
            if (wd[0]) o_trig_run <= sw_mask;
            if (wd[1]) o_wvb_arm <= arm_mask;
          end
          ADR_BUF_SEL:    o_buf_sel <= wd[CH_SEL_W-1:0];
          ADR_IO_SEL:     o_io_sel <= wd[CH_SEL_W-1:0];
          // lane 0 in the low nibble, lane 1 in the next
          ADR_IO_STROBE: begin
            o_io_pattern.delay_inc    <= {wd[4], wd[0]};
            o_io_pattern.delay_ce     <= {wd[5], wd[1]};
            o_io_pattern.adc_bitslip  <= {wd[6], wd[2]};
            o_io_pattern.disc_bitslip <= wd[8];
          end
          ADR_ADC_SEL:          adc_sel <= wd[5:0];
          ADR_ADC_TASK:         o_adc_start <= wd[0];
          ADR_ADC_DATA_HI:      adc_data[23:16] <= wd[7:0];
          ADR_ADC_DATA_LO:      adc_data[15:0] <= wd;
          ADR_DAC_SEL:          dac_sel <= wd[2:0];
          ADR_DAC_TASK:         o_dac_start <= wd[0];
          ADR_DAC_DATA_HI:      dac_data[31:16] <= wd;
          ADR_DAC_DATA_LO:      dac_data[15:0] <= wd;
          ADR_PULSER_WIDTH:     o_pulser_width <= wd;
          ADR_PULSER_SINGLE:    o_pulser_single <= wd[PULSER_N-1:0];
          ADR_PULSER_PERIOD_HI: o_pulser_period[31:16] <= wd;
          ADR_PULSER_PERIOD_LO: o_pulser_period[15:0] <= wd;
          ADR_PULSER_EN:        o_pulser_en <= wd[PULSER_N-1:0];
          ADR_SCALER_SEL:       o_scaler_sel <= wd[CH_SEL_W-1:0];
          default: ;
        endcase
      end
    end
  end

  assign o_adc_cmd = '{req: 1'b0, sel: adc_sel, data: {8'h00, adc_data}};
  assign o_dac_cmd = '{req: 1'b0, sel: {3'b000, dac_sel}, data: dac_data};

  //////////////////////////////////////////////////////////////////////////
  // read side
  always_comb begin
    case (i_bus.adr)
      ADR_VNUM:             rd_word = i_vnum;
      ADR_TRIG_CONF:        rd_word = 16'(o_trig_conf[18:12]);
      ADR_TRIG_THR:         rd_word = 16'(o_trig_conf.thr);
      ADR_SW_MASK_HI:       rd_word = 16'(sw_mask[N_CHANNELS-1:16]);
      ADR_SW_MASK_LO:       rd_word = sw_mask[15:0];
      ADR_ARM_MASK_HI:      rd_word = 16'(arm_mask[N_CHANNELS-1:16]);
      ADR_ARM_MASK_LO:      rd_word = arm_mask[15:0];
      ADR_ARMED_HI:         rd_word = 16'(i_wvb_armed[N_CHANNELS-1:16]);
      ADR_ARMED_LO:         rd_word = i_wvb_armed[15:0];
      ADR_BUF_SEL:          rd_word = 16'(o_buf_sel);
      ADR_BUF_WDS:          rd_word = i_wds_sel_data;
      ADR_IO_SEL:           rd_word = 16'(o_io_sel);
      ADR_ADC_SEL:          rd_word = 16'(adc_sel);
      ADR_ADC_TASK:         rd_word = 16'(i_adc_task_val);
      ADR_ADC_DATA_HI:      rd_word = 16'(adc_data[23:16]);
      ADR_ADC_DATA_LO:      rd_word = adc_data[15:0];
      ADR_ADC_RD:           rd_word = 16'(i_adc_rd_data);
      ADR_DAC_SEL:          rd_word = 16'(dac_sel);
      ADR_DAC_TASK:         rd_word = 16'(i_dac_task_val);
      ADR_DAC_DATA_HI:      rd_word = dac_data[31:16];
      ADR_DAC_DATA_LO:      rd_word = dac_data[15:0];
      ADR_PULSER_WIDTH:     rd_word = o_pulser_width;
      ADR_PULSER_SINGLE:    rd_word = 16'(o_pulser_single);
      ADR_PULSER_PERIOD_HI: rd_word = o_pulser_period[31:16];
      ADR_PULSER_PERIOD_LO: rd_word = o_pulser_period[15:0];
      ADR_PULSER_EN:        rd_word = 16'(o_pulser_en);
      ADR_SCALER_SEL:       rd_word = 16'(o_scaler_sel);
      ADR_SCALER_HI:        rd_word = i_scaler_sel_data[31:16];
      ADR_SCALER_LO:        rd_word = i_scaler_sel_data[15:0];
      default:              rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= i_bus.rd;
    end
    if (i_bus.rd) begin
      rd_data <= rd_word;
    end
  end

  assign o_rd = '{valid: rd_valid, data: rd_data};

endmodule

// File: hdl/xdom_top.sv
// xdom register core top: host registers, serial-bus tasks, status muxes, io strobes, pulser
module xdom_top import xdom_pkg::*; #(
  parameter int N_CHANNELS = 24
) (
  input  logic                          clk,
  input  logic                          rst,
  input  host_bus_t                     i_bus,
  output rd_resp_t                      o_rd,
  input  logic [15:0]                   i_vnum,

  input  logic [N_CHANNELS-1:0]         i_wvb_armed,
  input  logic [N_CHANNELS-1:0][15:0]   i_buf_wds_used,
  input  logic [N_CHANNELS-1:0][31:0]   i_disc_scaler,

  output trig_conf_t                    o_trig_conf,
  output logic [N_CHANNELS-1:0]         o_trig_run,
  output logic [N_CHANNELS-1:0]         o_wvb_arm,
  output io_strobe_t [N_CHANNELS-1:0]   o_io_strobe,

  output spi_cmd_t                      o_adc_spi,
  output spi_cmd_t                      o_dac_spi,
  input  logic                          i_adc_ack,
  input  logic [7:0]                    i_adc_rd_data,
  input  logic                          i_dac_ack,

  output logic [PULSER_N-1:0]           o_pulser_trig,
  output logic [15:0]                   o_pulser_width
);

  logic [15:0]         wds_sel_data;
  logic [31:0]         scaler_sel_data;
  logic [CH_SEL_W-1:0] buf_sel;
  logic [CH_SEL_W-1:0] scaler_sel;
  logic [CH_SEL_W-1:0] io_sel;
  io_strobe_t          io_pattern;
  logic                adc_start;
  logic                dac_start;
  logic                adc_req;
  logic                dac_req;
  logic                adc_task_val;
  logic                dac_task_val;
  spi_cmd_t            adc_cmd;
  spi_cmd_t            dac_cmd;
  logic [PULSER_N-1:0] pulser_single;
  logic [PULSER_N-1:0] pulser_en;
  logic [31:0]         pulser_period;
  logic                pulser_tick;

  reg_file #(.N_CHANNELS(N_CHANNELS)) u_reg_file (
    .clk(clk), .rst(rst), .i_bus(i_bus), .o_rd(o_rd), .i_vnum(i_vnum),
    .i_wvb_armed(i_wvb_armed), .i_wds_sel_data(wds_sel_data),
    .i_scaler_sel_data(scaler_sel_data), .i_adc_rd_data(i_adc_rd_data),
    .i_adc_task_val(adc_task_val), .i_dac_task_val(dac_task_val),
    .o_adc_start(adc_start), .o_dac_start(dac_start),
    .o_adc_cmd(adc_cmd), .o_dac_cmd(dac_cmd),
    .o_buf_sel(buf_sel), .o_scaler_sel(scaler_sel), .o_io_sel(io_sel),
    .o_io_pattern(io_pattern), .o_trig_conf(o_trig_conf),
    .o_trig_run(o_trig_run), .o_wvb_arm(o_wvb_arm),
    .o_pulser_single(pulser_single), .o_pulser_en(pulser_en),
    .o_pulser_period(pulser_period), .o_pulser_width(o_pulser_width)
  );

  task_handshake adc_task (
    .clk(clk), .rst(rst), .i_start(adc_start), .i_ack(i_adc_ack),
    .o_req(adc_req), .o_val(adc_task_val)
  );

  task_handshake dac_task (
    .clk(clk), .rst(rst), .i_start(dac_start), .i_ack(i_dac_ack),
    .o_req(dac_req), .o_val(dac_task_val)
  );

  // request bit comes from the handshake, fields from the registers
  assign o_adc_spi = '{req: adc_req, sel: adc_cmd.sel, data: adc_cmd.data};
  assign o_dac_spi = '{req: dac_req, sel: dac_cmd.sel, data: dac_cmd.data};

  channel_sel_mux #(.payload_t(logic [15:0]), .N_CHANNELS(N_CHANNELS)) wds_mux (
    .clk(clk), .i_sel(buf_sel), .i_data(i_buf_wds_used), .o_data(wds_sel_data)
  );

  channel_sel_mux #(.payload_t(logic [31:0]), .N_CHANNELS(N_CHANNELS)) scaler_mux (
    .clk(clk), .i_sel(scaler_sel), .i_data(i_disc_scaler), .o_data(scaler_sel_data)
  );

  io_strobe_demux #(.N_CHANNELS(N_CHANNELS)) u_io_demux (
    .clk(clk), .rst(rst), .i_sel(io_sel), .i_pattern(io_pattern), .o_strobe(o_io_strobe)
  );

  periodic_trigger u_pulser_timer (
    .clk(clk), .rst(rst), .i_period(pulser_period), .o_trig(pulser_tick)
  );

  // single shots plus enabled periodic ticks
  assign o_pulser_trig = pulser_single | ({PULSER_N{pulser_tick}} & pulser_en);

endmodule

// File: tests/tb_xdom.sv
// xdom register core testbench driving a host access table against serial-bus device models
module tb_xdom import xdom_pkg::*; ();

  localparam int N_CH = 24;
  localparam int WINDOW = 210;
  localparam logic [15:0] VNUM = 16'h0a17;
  localparam logic [7:0] ADC_RD_VAL = 8'hc7;

  typedef enum logic [3:0] {
    K_WR, K_RD, K_CONF, K_WIDTH, K_CMD, K_IO, K_TASK, K_SINGLE, K_PERIOD
  } kind_t;

  typedef struct packed {
    kind_t             kind;
    logic [ADR_W-1:0]  adr;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] exp;
    logic [31:0]       wide;
  } entry_t;

  logic                  clk;
  logic                  rst;
  host_bus_t             bus;
  rd_resp_t              rd_resp;
  logic [N_CH-1:0]       armed;
  logic [N_CH-1:0][15:0] wds_used;
  logic [N_CH-1:0][31:0] disc_scaler;
  trig_conf_t            trig_conf;
  logic [N_CH-1:0]       trig_run;
  logic [N_CH-1:0]       wvb_arm;
  io_strobe_t [N_CH-1:0] io_strobe;
  spi_cmd_t              adc_spi;
  spi_cmd_t              dac_spi;
  logic                  adc_ack;
  logic                  dac_ack;
  logic [7:0]            adc_rd_data;
  logic [PULSER_N-1:0]   pulser_trig;
  logic [15:0]           pulser_width;
  logic [31:0]           lfsr;
  int                    adc_wait;
  int                    dac_wait;
  int                    cycles;
  int                    limit;
  int                    errors;
  int                    failed;
  string                 names[$];
  entry_t                table_q[$];

  xdom_top #(.N_CHANNELS(N_CH)) DUT (
    .clk(clk), .rst(rst), .i_bus(bus), .o_rd(rd_resp), .i_vnum(VNUM),
    .i_wvb_armed(armed), .i_buf_wds_used(wds_used), .i_disc_scaler(disc_scaler),
    .o_trig_conf(trig_conf), .o_trig_run(trig_run), .o_wvb_arm(wvb_arm),
    .o_io_strobe(io_strobe), .o_adc_spi(adc_spi), .o_dac_spi(dac_spi),
    .i_adc_ack(adc_ack), .i_adc_rd_data(adc_rd_data), .i_dac_ack(dac_ack),
    .o_pulser_trig(pulser_trig), .o_pulser_width(pulser_width)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: run still going after %0d cycles", limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // device models ack for one cycle on the fourth cycle of a request
  always @(negedge clk) begin
    if (adc_ack) begin
      adc_ack <= 1'b0;
    end else if (adc_spi.req) begin
      adc_wait <= adc_wait + 1;
      if (adc_wait == 3) begin
        adc_ack     <= 1'b1;
        adc_rd_data <= ADC_RD_VAL;
        adc_wait    <= 0;
      end
    end
  end

  always @(negedge clk) begin
    if (dac_ack) begin
      dac_ack <= 1'b0;
    end else if (dac_spi.req) begin
      dac_wait <= dac_wait + 1;
      if (dac_wait == 3) begin
        dac_ack  <= 1'b1;
        dac_wait <= 0;
      end
    end
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] lfsr_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
    end
    return v;
  endfunction

  function automatic logic device_busy(logic [ADR_W-1:0] adr);
    if (adr == ADR_ADC_TASK) return adc_spi.req || adc_ack;
    return dac_spi.req || dac_ack;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checks
  task automatic check_word(string name, logic [15:0] exp, logic [15:0] act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_mask(string name, logic [N_CH-1:0] exp, logic [N_CH-1:0] act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_strobe(string name, io_strobe_t exp, io_strobe_t act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_spi(string name, spi_cmd_t exp, spi_cmd_t act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_conf(string name, trig_conf_t exp, trig_conf_t act);
    if (act !== exp) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // host bus, called on a falling edge
  task automatic bus_write(logic [ADR_W-1:0] adr, logic [DATA_W-1:0] data);
    bus = '{wr: 1'b1, rd: 1'b0, adr: adr, data: data};
    @(negedge clk);
    bus = '0;
  endtask

  task automatic bus_read(string name, logic [ADR_W-1:0] adr, output logic [DATA_W-1:0] data);
    bus = '{wr: 1'b0, rd: 1'b1, adr: adr, data: '0};
    @(negedge clk);
    bus = '0;
    if (rd_resp.valid !== 1'b1) begin
      $display("%s: no read response on the cycle after the strobe", name);
      errors++;
    end
    data = rd_resp.data;
  endtask

  task automatic add_entry(string name, kind_t kind, logic [ADR_W-1:0] adr,
                           logic [15:0] data, logic [15:0] exp, logic [31:0] wide);
    names.push_back(name);
    table_q.push_back('{kind: kind, adr: adr, data: data, exp: exp, wide: wide});
  endtask

  initial begin
    entry_t            e;
    trig_conf_t        conf;
    spi_cmd_t          cmd;
    io_strobe_t        pat;
    logic [DATA_W-1:0] word;
    int                base;
    int                exp_n;
    int                cnt [PULSER_N];
    clk = 1'b0;
    rst = 1'b1;
    bus = '0;
    adc_ack = 1'b0;
    dac_ack = 1'b0;
    adc_rd_data = 8'h00;
    adc_wait = 0;
    dac_wait = 0;
    cycles = 0;
    limit = 0;
    errors = 0;
    failed = 0;
    lfsr = 32'hd2372dca;
    for (int ch = 0; ch < N_CH; ch++) begin
      wds_used[ch] = 16'(lfsr_bits(16));
      disc_scaler[ch] = lfsr_bits(32);
    end
    armed = N_CH'(lfsr_bits(N_CH));

    add_entry("conf write", K_WR, ADR_TRIG_CONF, 16'hff5b, '0, '0);
    add_entry("thr write", K_WR, ADR_TRIG_THR, 16'hfa71, '0, '0);
    add_entry("conf read", K_RD, ADR_TRIG_CONF, '0, 16'h005b, '0);
    add_entry("conf port", K_CONF, '0, 16'h005b, 16'h0a71, '0);
    add_entry("sw mask lo write", K_WR, ADR_SW_MASK_LO, 16'h5a3c, '0, '0);
    add_entry("sw mask hi write", K_WR, ADR_SW_MASK_HI, 16'hffc1, '0, '0);
    add_entry("sw mask hi read", K_RD, ADR_SW_MASK_HI, '0, 16'h00c1, '0);
    add_entry("arm mask lo write", K_WR, ADR_ARM_MASK_LO, 16'h0ff0, '0, '0);
    add_entry("adc sel write", K_WR, ADR_ADC_SEL, 16'hffed, '0, '0);
    add_entry("adc data lo write", K_WR, ADR_ADC_DATA_LO, 16'h1e2f, '0, '0);
    add_entry("dac sel write", K_WR, ADR_DAC_SEL, 16'h0005, '0, '0);
    add_entry("dac data lo write", K_WR, ADR_DAC_DATA_LO, 16'h07e6, '0, '0);
    add_entry("dac data lo read", K_RD, ADR_DAC_DATA_LO, '0, 16'h07e6, '0);
    add_entry("vnum read", K_RD, ADR_VNUM, '0, VNUM, '0);
    add_entry("unmapped read", K_RD, 12'h123, '0, 16'h0000, '0);
    add_entry("armed lo read", K_RD, ADR_ARMED_LO, '0, armed[15:0], '0);
    add_entry("armed hi read", K_RD, ADR_ARMED_HI, '0, 16'(armed[N_CH-1:16]), '0);
    add_entry("buf sel write", K_WR, ADR_BUF_SEL, 16'd17, '0, '0);
    add_entry("buf words read", K_RD, ADR_BUF_WDS, '0, wds_used[17], '0);
    add_entry("buf sel out of range", K_WR, ADR_BUF_SEL, 16'd30, '0, '0);
    add_entry("buf words out of range", K_RD, ADR_BUF_WDS, '0, 16'h0000, '0);
    add_entry("scaler sel write", K_WR, ADR_SCALER_SEL, 16'd9, '0, '0);
    add_entry("scaler hi read", K_RD, ADR_SCALER_HI, '0, disc_scaler[9][31:16], '0);
    add_entry("scaler lo read", K_RD, ADR_SCALER_LO, '0, disc_scaler[9][15:0], '0);
    add_entry("sw trigger", K_CMD, ADR_TRIG_CMD, 16'h0001, '0, 32'h00c15a3c);
    add_entry("arm trigger", K_CMD, ADR_TRIG_CMD, 16'h0002, '0, 32'h00000ff0);
    add_entry("io sel write", K_WR, ADR_IO_SEL, 16'd5, '0, '0);
    add_entry("io strobe", K_IO, ADR_IO_STROBE, 16'h0135, 16'd5, '0);
    add_entry("adc task", K_TASK, ADR_ADC_TASK, 16'h0001, 16'h002d, 32'h00001e2f);
    add_entry("adc read data", K_RD, ADR_ADC_RD, '0, 16'(ADC_RD_VAL), '0);
    add_entry("dac task", K_TASK, ADR_DAC_TASK, 16'h0001, 16'h0005, 32'h000007e6);
    add_entry("pulser width write", K_WR, ADR_PULSER_WIDTH, 16'h3a5c, '0, '0);
    add_entry("pulser width read", K_RD, ADR_PULSER_WIDTH, '0, 16'h3a5c, '0);
    add_entry("pulser width port", K_WIDTH, '0, '0, 16'h3a5c, '0);
    add_entry("pulser single", K_SINGLE, ADR_PULSER_SINGLE, 16'h002d, '0, '0);
    add_entry("pulser periodic", K_PERIOD, ADR_PULSER_EN, 16'h0016, 16'd7, '0);
    limit = 40 * table_q.size() + 2000;

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    foreach (table_q[i]) begin
      e = table_q[i];
      base = errors;
      case (e.kind)
        K_WR: bus_write(e.adr, e.data);
        K_RD: begin
          bus_read(names[i], e.adr, word);
          check_word(names[i], e.exp, word);
        end
        K_CONF: begin
          conf = '{ext_en: e.data[6], thr_en: e.data[5], disc_en: e.data[4],
                   disc_pol: e.data[3], lt: e.data[2], gt: e.data[1], et: e.data[0],
                   thr: e.exp[11:0]};
          check_conf(names[i], conf, trig_conf);
        end
        K_WIDTH: check_word(names[i], e.exp, pulser_width);
        K_CMD: begin
          bus_write(e.adr, e.data);
          check_mask(names[i], {N_CH{e.data[0]}} & N_CH'(e.wide), trig_run);
          check_mask(names[i], {N_CH{e.data[1]}} & N_CH'(e.wide), wvb_arm);
          @(negedge clk);
          check_mask(names[i], '0, trig_run);
          check_mask(names[i], '0, wvb_arm);
        end
        K_IO: begin
          pat = '{delay_ce: {e.data[5], e.data[1]}, delay_inc: {e.data[4], e.data[0]},
                  adc_bitslip: {e.data[6], e.data[2]}, disc_bitslip: e.data[8]};
          bus_write(e.adr, e.data);
          @(negedge clk);
          for (int ch = 0; ch < N_CH; ch++) begin
            check_strobe(names[i], (ch == e.exp) ? pat : IO_STROBE_IDLE, io_strobe[ch]);
          end
          @(negedge clk);
          for (int ch = 0; ch < N_CH; ch++) begin
            check_strobe(names[i], IO_STROBE_IDLE, io_strobe[ch]);
          end
        end
        K_TASK: begin
          cmd = '{req: 1'b1, sel: e.exp[5:0], data: e.wide};
          bus_write(e.adr, e.data);
          @(negedge clk);
          check_spi(names[i], cmd, (e.adr == ADR_ADC_TASK) ? adc_spi : dac_spi);
          bus_read(names[i], e.adr, word);
          check_word(names[i], 16'h0001, word);
          // the device model ends the transfer
          while (device_busy(e.adr)) @(negedge clk);
          bus_read(names[i], e.adr, word);
          check_word(names[i], 16'h0000, word);
        end
        K_SINGLE: begin
          bus_write(e.adr, e.data);
          check_mask(names[i], N_CH'(e.data[PULSER_N-1:0]), N_CH'(pulser_trig));
          @(negedge clk);
          check_mask(names[i], '0, N_CH'(pulser_trig));
        end
        default: begin
          bus_write(ADR_PULSER_EN, e.data);
          bus_write(ADR_PULSER_PERIOD_LO, e.exp);
          cnt = '{default: 0};
          repeat (WINDOW) begin
            @(negedge clk);
            for (int p = 0; p < PULSER_N; p++) cnt[p] += int'(pulser_trig[p]);
          end
          bus_write(ADR_PULSER_PERIOD_LO, 16'h0000);
          for (int p = 0; p < PULSER_N; p++) begin
            exp_n = e.data[p] ? WINDOW / int'(e.exp) : 0;
            if (cnt[p] < exp_n - 1 || cnt[p] > exp_n + 1 || (exp_n == 0 && cnt[p] != 0)) begin
              $display("Fail %s output %0d expected %0d actual %0d", names[i], p, exp_n, cnt[p]);
              errors++;
            end
          end
        end
      endcase
      @(negedge clk);
      if (errors == base) begin
        $display("ok   %s", names[i]);
      end else begin
        $display("bad  %s", names[i]);
        failed++;
      end
    end

    $display("%0d tests run, %0d failed, %0d errors", table_q.size(), failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
hdl/xdom_pkg.sv
hdl/task_handshake.sv
hdl/channel_sel_mux.sv
hdl/io_strobe_demux.sv
hdl/periodic_trigger.sv
hdl/reg_file.sv
hdl/xdom_top.sv
tests/tb_xdom.sv

// File: Bender.yml
package:
  name: xdom_regs

sources:
  - files:
      - hdl/xdom_pkg.sv
      - hdl/task_handshake.sv
      - hdl/channel_sel_mux.sv
      - hdl/io_strobe_demux.sv
      - hdl/periodic_trigger.sv
      - hdl/reg_file.sv
      - hdl/xdom_top.sv
  - target: test
    files:
      - tests/tb_xdom.sv
